// ==== hw/video_pkg.sv ====
package video_pkg;

    localparam int LUT_ADDR_W = 8;      // palette index width
    localparam int CHAN_W     = 4;      // one color channel
    localparam int RGB_W      = 3 * CHAN_W;
    localparam int ARGB_W     = 16;     // one palette word

    // blend view, used for the B word
    typedef struct packed {
        logic [CHAN_W-1:0] alpha;
        logic [CHAN_W-1:0] red;
        logic [CHAN_W-1:0] green;
        logic [CHAN_W-1:0] blue;
    } argb_blend_t;

    // priority view, used for the A word
    typedef struct packed {
        logic             pri;          // A drawn opaque on top
        logic [2:0]       rsvd;
        logic [RGB_W-1:0] rgb;
    } argb_pri_t;

    // one palette word, decoded per playfield
    typedef union packed {
        argb_blend_t       blend;
        argb_pri_t         prio;
        logic [ARGB_W-1:0] raw;         // host writes land here
    } argb_u;

endpackage

// ==== hw/video_if.sv ====
`timescale 1ns/1ns

// one pixel stream after palette lookup, no handshake
interface video_if;

    logic vsync;
    logic hsync;
    logic de;                           // pixel valid when high

    video_pkg::argb_u color_a;          // playfield A palette word
    video_pkg::argb_u color_b;          // playfield B palette word

    modport source (
        output vsync,
        output hsync,
        output de,
        output color_a,
        output color_b
    );

    modport sink (
        input vsync,
        input hsync,
        input de,
        input color_a,
        input color_b
    );

endinterface

// ==== hw/color_lut.sv ====
`timescale 1ns/1ns

module color_lut #(
    parameter bit LUT_IS_B = 1'b0       // which payload word this palette fills
) (
    input  logic                              clk,
    input  logic                              rst_i,

    // host write port
    input  logic                              wr_en_i,
    input  logic [video_pkg::LUT_ADDR_W-1:0]  wr_addr_i,
    input  video_pkg::argb_u                  wr_data_i,

    // raster side
    input  logic                              vsync_i,
    input  logic                              hsync_i,
    input  logic                              de_i,
    input  logic [video_pkg::LUT_ADDR_W-1:0]  index_i,

    video_if.source                           pix_o
);

    // palette storage, contents survive reset
    video_pkg::argb_u mem [2**video_pkg::LUT_ADDR_W];

    video_pkg::argb_u rd_word;          // registered read data
    logic             vsync_q;
    logic             hsync_q;
    logic             de_q;

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // separate read port, a same-cycle write is not seen until next clock
    always_ff @(posedge clk) begin
        rd_word <= mem[index_i];
    end

    // timing signals ride along with the read latency
    always_ff @(posedge clk) begin
        if (rst_i) begin
            vsync_q <= 1'b0;
            hsync_q <= 1'b0;
            de_q    <= 1'b0;
        end else begin
            vsync_q <= vsync_i;
            hsync_q <= hsync_i;
            de_q    <= de_i;
        end
    end

    assign pix_o.vsync = vsync_q;
    assign pix_o.hsync = hsync_q;
    assign pix_o.de    = de_q;

    // the other playfield's word is tied off on this stream
    generate
        if (LUT_IS_B) begin : g_word_b
            assign pix_o.color_b = rd_word;
            assign pix_o.color_a = '0;
        end else begin : g_word_a
            assign pix_o.color_a = rd_word;
            assign pix_o.color_b = '0;
        end
    endgenerate

endmodule

// ==== hw/video_blend.sv ====
`timescale 1ns/1ns

module video_blend #(
    parameter bit EN_BLEND = 1'b1       // 0 gives plain overlay
) (
    input  logic                         clk,
    input  logic                         rst_i,

    video_if.sink                        pix_i,

    output logic [video_pkg::RGB_W-1:0]  rgb_o,
    output logic                         hsync_o,
    output logic                         vsync_o,
    output logic                         de_o
);

    localparam int CW = video_pkg::CHAN_W;

    video_pkg::argb_pri_t    word_a;    // A seen through the priority view
    video_pkg::argb_blend_t  word_b;    // B seen through the blend view
    logic [video_pkg::RGB_W-1:0] mix_rgb;

    // B over A for one channel, A weighted by 15 - alpha and B by alpha
    function automatic logic [CW-1:0] mix_chan(
        input logic [CW-1:0] chan_a,
        input logic [CW-1:0] chan_b,
        input logic [CW-1:0] alpha
    );
        logic [2*CW-1:0] ext_a;
        logic [2*CW-1:0] ext_b;
        logic [3*CW-1:0] prod_a;
        logic [3*CW-1:0] prod_b;
        logic [3*CW-1:0] sum;
        ext_a  = {chan_a, chan_a};      // c * 17
        ext_b  = {chan_b, chan_b};
        prod_a = {{CW{1'b0}}, ext_a} * {{(2*CW){1'b0}}, ~alpha};
        prod_b = {{CW{1'b0}}, ext_b} * {{(2*CW){1'b0}}, alpha};
        sum    = (prod_a >> CW) + (prod_b >> CW);
        return sum[CW-1:0];             // wraps, no clamp
    endfunction

    assign word_a = pix_i.color_a.prio;
    assign word_b = pix_i.color_b.blend;

    generate
        if (EN_BLEND) begin : g_alpha
            always_comb begin
                if (word_a.pri) begin
                    mix_rgb = word_a.rgb;   // A opaque on top
                end else begin
                    mix_rgb = {mix_chan(word_a.rgb[3*CW-1:2*CW], word_b.red,   word_b.alpha),
                               mix_chan(word_a.rgb[2*CW-1:CW],   word_b.green, word_b.alpha),
                               mix_chan(word_a.rgb[CW-1:0],      word_b.blue,  word_b.alpha)};
                end
            end
        end else begin : g_overlay
            // B wins only where A has no priority and B is mostly opaque
            always_comb begin
                if (!word_a.pri && word_b.alpha[CW-1]) begin
                    mix_rgb = {word_b.red, word_b.green, word_b.blue};
                end else begin
                    mix_rgb = word_a.rgb;
                end
            end
        end
    endgenerate

    // one register stage, pixel blanked outside the active area
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rgb_o   <= '0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
        end else begin
            rgb_o   <= pix_i.de ? mix_rgb : '0;
            hsync_o <= pix_i.hsync;
            vsync_o <= pix_i.vsync;
            de_o    <= pix_i.de;
        end
    end

endmodule

// ==== hw/video_mixer_top.sv ====
`timescale 1ns/1ns

module video_mixer_top #(
    parameter bit EN_BLEND = 1'b1
) (
    input  logic                              clk,
    input  logic                              rst_i,

    // host palette writes
    input  logic                              pal_we_i,
    input  logic                              pal_sel_i,    // 0 = A, 1 = B
    input  logic [video_pkg::LUT_ADDR_W-1:0]  pal_addr_i,
    input  logic [video_pkg::ARGB_W-1:0]      pal_data_i,

    // raster in
    input  logic                              vsync_i,
    input  logic                              hsync_i,
    input  logic                              de_i,
    input  logic [video_pkg::LUT_ADDR_W-1:0]  index_a_i,
    input  logic [video_pkg::LUT_ADDR_W-1:0]  index_b_i,

    // pixel out, two clocks behind the raster in
    output logic [video_pkg::RGB_W-1:0]       rgb_o,
    output logic                              hsync_o,
    output logic                              vsync_o,
    output logic                              de_o
);

    video_pkg::argb_u wr_word;
    logic             we_a;
    logic             we_b;

    video_if pix_a ();                  // lut A stream, carries the timing
    video_if pix_b ();                  // lut B stream, only color_b is used
    video_if pix_mix ();                // merged stream into the blender

    assign wr_word.raw = pal_data_i;
    assign we_a = pal_we_i & ~pal_sel_i;
    assign we_b = pal_we_i & pal_sel_i;

    color_lut #(
        .LUT_IS_B (1'b0)
    ) u_lut_a (
        .clk       (clk),
        .rst_i     (rst_i),
        .wr_en_i   (we_a),
        .wr_addr_i (pal_addr_i),
        .wr_data_i (wr_word),
        .vsync_i   (vsync_i),
        .hsync_i   (hsync_i),
        .de_i      (de_i),
        .index_i   (index_a_i),
        .pix_o     (pix_a)
    );

    color_lut #(
        .LUT_IS_B (1'b1)
    ) u_lut_b (
        .clk       (clk),
        .rst_i     (rst_i),
        .wr_en_i   (we_b),
        .wr_addr_i (pal_addr_i),
        .wr_data_i (wr_word),
        .vsync_i   (vsync_i),
        .hsync_i   (hsync_i),
        .de_i      (de_i),
        .index_i   (index_b_i),
        .pix_o     (pix_b)
    );

    // both luts have the same latency, so A's timing serves for both words
    assign pix_mix.vsync   = pix_a.vsync;
    assign pix_mix.hsync   = pix_a.hsync;
    assign pix_mix.de      = pix_a.de;
    assign pix_mix.color_a = pix_a.color_a;
    assign pix_mix.color_b = pix_b.color_b;

    video_blend #(
        .EN_BLEND (EN_BLEND)
    ) u_blend (
        .clk     (clk),
        .rst_i   (rst_i),
        .pix_i   (pix_mix),
        .rgb_o   (rgb_o),
        .hsync_o (hsync_o),
        .vsync_o (vsync_o),
        .de_o    (de_o)
    );

endmodule

// ==== sim/video_mixer_assertions.sv ====
`timescale 1ns/1ns

// checks on the mixer outputs against its raster inputs
module video_mixer_assertions (
    input logic                         clk,
    input logic                         rst_i,

    // raster in
    input logic                         vsync_i,
    input logic                         hsync_i,
    input logic                         de_i,

    // pixel out
    input logic [video_pkg::RGB_W-1:0]  rgb_out_i,
    input logic                         hsync_out_i,
    input logic                         vsync_out_i,
    input logic                         de_out_i
);

    // two register stages, both must be out of reset
    property p_timing_lag;
        @(posedge clk) disable iff (rst_i)
            (!$past(rst_i) && !$past(rst_i, 2)) |->
                (de_out_i == $past(de_i, 2) &&
                 hsync_out_i == $past(hsync_i, 2) &&
                 vsync_out_i == $past(vsync_i, 2));
    endproperty

    property p_blank_rgb;
        @(posedge clk) !de_out_i |-> (rgb_out_i == '0);
    endproperty

    property p_reset_idle;
        @(posedge clk) $past(rst_i) |->
            (!de_out_i && !hsync_out_i && !vsync_out_i && rgb_out_i == '0);
    endproperty

    a_timing_lag: assert property (p_timing_lag)
        else $error("syncs or de do not lag the raster inputs by two clocks");

    a_blank_rgb: assert property (p_blank_rgb)
        else $error("rgb nonzero while de is low");

    a_reset_idle: assert property (p_reset_idle)
        else $error("outputs not idle in the cycle after reset");

endmodule

// ==== sim/tb_video_mixer.sv ====
`timescale 1ns/1ns

module tb_video_mixer;

    localparam int RESET_TIMEOUT = 20;          // cycles
    localparam int DRAIN_TIMEOUT = 20;

    logic                              clk;
    logic                              rst_i = 1'b1;
    logic                              pal_we_i;
    logic                              pal_sel_i;
    logic [video_pkg::LUT_ADDR_W-1:0]  pal_addr_i;
    logic [video_pkg::ARGB_W-1:0]      pal_data_i;
    logic                              vsync_i;
    logic                              hsync_i;
    logic                              de_i;
    logic [video_pkg::LUT_ADDR_W-1:0]  index_a_i;
    logic [video_pkg::LUT_ADDR_W-1:0]  index_b_i;
    logic [video_pkg::RGB_W-1:0]       rgb_o;
    logic                              hsync_o;
    logic                              vsync_o;
    logic                              de_o;

    // model copies of both palettes that follow every host write
    logic [15:0] pal_a [256];
    logic [15:0] pal_b [256];

    logic [14:0] exp_q [$];                     // {de, hsync, vsync, rgb} per driven cycle
    logic [14:0] exp_word;
    int          driven_cnt = 0;
    int          checked_cnt = 0;

    video_mixer_top i_video_mixer_top (
        .clk        (clk),
        .rst_i      (rst_i),
        .pal_we_i   (pal_we_i),
        .pal_sel_i  (pal_sel_i),
        .pal_addr_i (pal_addr_i),
        .pal_data_i (pal_data_i),
        .vsync_i    (vsync_i),
        .hsync_i    (hsync_i),
        .de_i       (de_i),
        .index_a_i  (index_a_i),
        .index_b_i  (index_b_i),
        .rgb_o      (rgb_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .de_o       (de_o)
    );

    bind video_mixer_top video_mixer_assertions u_mixer_assertions (
        .clk         (clk),
        .rst_i       (rst_i),
        .vsync_i     (vsync_i),
        .hsync_i     (hsync_i),
        .de_i        (de_i),
        .rgb_out_i   (rgb_o),
        .hsync_out_i (hsync_o),
        .vsync_out_i (vsync_o),
        .de_out_i    (de_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    initial begin
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [7:0] rand8();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = $urandom();
        return r[15:0];
    endfunction

    // priority bit wins or B is laid over A with B's alpha per 4-bit channel
    function automatic logic [11:0] blend_ref(input logic [15:0] wa, input logic [15:0] wb);
        int          alpha;
        int          ca;
        int          cb;
        int          mix;
        int          ch;
        logic [11:0] pix;
        if (wa[15]) begin
            return wa[11:0];
        end
        alpha = int'(wb[15:12]);
        for (ch = 0; ch < 3; ch++) begin
            ca  = int'(wa[ch*4 +: 4]);
            cb  = int'(wb[ch*4 +: 4]);
            mix = ((ca * 17 * (15 - alpha)) >> 4) + ((cb * 17 * alpha) >> 4);
            pix[ch*4 +: 4] = 4'(mix % 16);      // kept to 4 bits
        end
        return pix;
    endfunction

    // one clock of stimulus with the expectation taken before the write lands
    task automatic drive_cycle(
        input logic        we,
        input logic        sel,
        input logic [7:0]  addr,
        input logic [15:0] data,
        input logic        vs,
        input logic        hs,
        input logic        de,
        input logic [7:0]  ia,
        input logic [7:0]  ib
    );
        logic [11:0] rgb;
        @(posedge clk);
        pal_we_i   <= we;
        pal_sel_i  <= sel;
        pal_addr_i <= addr;
        pal_data_i <= data;
        vsync_i    <= vs;
        hsync_i    <= hs;
        de_i       <= de;
        index_a_i  <= ia;
        index_b_i  <= ib;
        rgb = de ? blend_ref(pal_a[ia], pal_b[ib]) : 12'h000;
        exp_q.push_back({de, hs, vs, rgb});
        driven_cnt++;
        if (we && sel) begin
            pal_b[addr] = data;
        end else if (we) begin
            pal_a[addr] = data;
        end
    endtask

    task automatic write_palette(input logic sel, input logic [7:0] addr, input logic [15:0] data);
        drive_cycle(1'b1, sel, addr, data, 1'b0, 1'b0, 1'b0, 8'h00, 8'h00);
    endtask

    task automatic show_pixel(input logic [7:0] ia, input logic [7:0] ib);
        drive_cycle(1'b0, 1'b0, 8'h00, 16'h0000, 1'b0, 1'b0, 1'b1, ia, ib);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 1'b0, 8'h00, 16'h0000, 1'b0, 1'b0, 1'b0, 8'h00, 8'h00);
    endtask

    // priority set on the lower half of A and B's alpha follows the low index bits
    task automatic load_palettes();
        logic [15:0] r;
        for (int i = 0; i < 256; i++) begin
            r = rand16();
            write_palette(1'b0, 8'(i), {~i[7], 3'b000, r[11:0] ^ {4'h0, 8'(i)}});
            r = rand16();
            write_palette(1'b1, 8'(i), {i[3:0], r[11:0] ^ {8'(i), 4'h0}});
        end
    endtask

    task automatic priority_pixels();
        logic [7:0] r;
        for (int i = 0; i < 64; i++) begin
            r = rand8();
            show_pixel({1'b0, r[6:0]}, rand8());
        end
    endtask

    task automatic blend_sweep();
        logic [7:0] ra;
        logic [7:0] rb;
        for (int alpha = 0; alpha < 16; alpha++) begin
            for (int n = 0; n < 4; n++) begin
                ra = rand8();
                rb = rand8();
                show_pixel({1'b1, ra[6:0]}, {rb[3:0], 4'(alpha)});
            end
        end
    endtask

    task automatic blanking_runs();
        int   run_len;
        int   cyc;
        logic de_lvl;
        logic hs_lvl;
        logic vs_lvl;
        cyc    = 0;
        de_lvl = 1'b1;
        hs_lvl = 1'b0;
        vs_lvl = 1'b0;
        for (int run = 0; run < 24; run++) begin
            run_len = $urandom_range(8, 1);
            for (int k = 0; k < run_len; k++) begin
                if (cyc % 5 == 0) hs_lvl = ~hs_lvl;
                if (cyc % 23 == 0) vs_lvl = ~vs_lvl;
                drive_cycle(1'b0, 1'b0, 8'h00, 16'h0000, vs_lvl, hs_lvl, de_lvl,
                            rand8(), rand8());
                cyc++;
            end
            de_lvl = ~de_lvl;
        end
    endtask

    task automatic write_select();
        write_palette(1'b0, 8'h5c, 16'h0a53);   // A word, priority clear
        write_palette(1'b1, 8'h5c, 16'h93c6);   // B word, alpha 9
        show_pixel(8'h5c, 8'h5c);
        show_pixel(8'h5c, 8'h17);
        show_pixel(8'hc0, 8'h5c);
        idle_cycle();
    endtask

    // the same-cycle read sees the old word and the next read the new one
    task automatic write_during_display();
        show_pixel(8'h9a, 8'h21);
        drive_cycle(1'b1, 1'b0, 8'h9a, 16'h8e17, 1'b0, 1'b0, 1'b1, 8'h9a, 8'h21);
        show_pixel(8'h9a, 8'h21);
        show_pixel(8'h9a, 8'h21);
        drive_cycle(1'b1, 1'b1, 8'h21, 16'hf3b8, 1'b0, 1'b0, 1'b1, 8'h47, 8'h21);
        show_pixel(8'h47, 8'h21);
        show_pixel(8'h47, 8'h21);
    endtask

    task automatic wait_reset_done();
        int waited;
        waited = 0;
        while (rst_i) begin
            @(posedge clk);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                report_failure("timeout: reset was never released");
            end
        end
    endtask

    task automatic drain_pipeline();
        int target;
        int waited;
        target = driven_cnt;
        waited = 0;
        while (checked_cnt < target) begin
            idle_cycle();
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                report_failure("timeout: pixels still in flight after the stimulus ended");
            end
        end
    endtask

    // outputs are two clocks behind and compared mid-cycle
    always @(negedge clk) begin
        if (exp_q.size() >= 3) begin
            exp_word = exp_q.pop_front();
            checked_cnt++;
            assert ({de_o, hsync_o, vsync_o} == exp_word[14:12]) else
                report_failure($sformatf("CHECK FAILED at %0t ns: de/hsync/vsync %b, expected %b",
                                         $time, {de_o, hsync_o, vsync_o}, exp_word[14:12]));
            assert (rgb_o == exp_word[11:0]) else
                report_failure($sformatf("CHECK FAILED at %0t ns: rgb_o %h, expected %h",
                                         $time, rgb_o, exp_word[11:0]));
        end
    end

    initial begin
        void'($urandom(32'h8800b7bd));
        pal_we_i   = 1'b0;
        pal_sel_i  = 1'b0;
        pal_addr_i = '0;
        pal_data_i = '0;
        vsync_i    = 1'b1;                      // raster held active through reset
        hsync_i    = 1'b1;
        de_i       = 1'b1;
        index_a_i  = '0;
        index_b_i  = '0;

        wait_reset_done();
        @(negedge clk);
        assert (!de_o && !hsync_o && !vsync_o && rgb_o == '0) else
            report_failure($sformatf("CHECK FAILED at %0t ns: outputs not idle after reset",
                                     $time));

        load_palettes();
        priority_pixels();
        blend_sweep();
        blanking_runs();
        write_select();
        write_during_display();
        drain_pipeline();

        $display("sim passed");
        $finish;
    end

endmodule

// ==== files.f ====
hw/video_pkg.sv
hw/video_if.sv
hw/color_lut.sv
hw/video_blend.sv
hw/video_mixer_top.sv
sim/video_mixer_assertions.sv
sim/tb_video_mixer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the video mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f files.f \
    --top-module tb_video_mixer -o tb_video_mixer \
    && ./obj_dir/tb_video_mixer > "$LOG" 2>&1 \
    || echo "build or simulation returned an error status" >> "$LOG"

if grep -q "sim failed" "$LOG" || ! grep -q "sim passed" "$LOG"; then
    echo "FAIL: see $LOG"
    exit 1
fi

echo "PASS"
exit 0
